// ==== usb_transaction.f ====
hdl/usb_pid_pkg.sv
hdl/ctl_xfer_pkg.sv
hdl/setup_req_if.sv
hdl/token_router.sv
hdl/setup_parser.sv
hdl/control_fsm.sv
hdl/in_packet_tx.sv
hdl/usb_transaction.sv
dv/usb_transaction_sva.sv
dv/tb_usb_transaction.sv

// ==== Makefile ====
# Verilator build and run of the USB control transfer testbench

VERILATOR ?= verilator
TOP       ?= tb_usb_transaction
FILELIST  ?= usb_transaction.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/tb_usb_transaction.sv ====
module tb_usb_transaction;
  timeunit 1ns;
  timeprecision 1ps;

  localparam time         CLK_PERIOD  = 8;
  localparam logic [31:0] SEED        = 32'h9403;
  localparam int          NUM_TESTS   = 4;
  // Generous bound on one whole transfer, in clocks
  localparam int          XFER_CYCLES = 400;
  localparam int          CTL_ENDP    = 0;
  localparam logic [3:0]  CTL_EP      = 4'(CTL_ENDP);
  localparam logic [6:0]  DEV_ADDR    = 7'h2a;

  // Bus codes
  localparam logic [1:0] TOK_OUT   = 2'b00;
  localparam logic [1:0] TOK_IN    = 2'b10;
  localparam logic [1:0] TOK_SETUP = 2'b11;
  localparam logic [1:0] HSK_ACK   = 2'b00;
  localparam logic [1:0] DATA0     = 2'b00;
  localparam logic [1:0] DATA1     = 2'b10;

  typedef struct packed {
    logic [7:0]  rtype;
    logic [7:0]  rargs;
    logic [15:0] value;
    logic [15:0] index;
    logic [15:0] length;
  } setup_t;

  logic        clock, reset;
  logic [6:0]  usb_addr_i, tok_addr_i;
  logic [3:0]  tok_endp_i;
  logic [1:0]  tok_type_i, hsk_type_i, usb_type_i, hsk_type_o, trn_type_o;
  logic        tok_recv_i, hsk_recv_i, hsk_sent_i, usb_recv_i, trn_busy_i;
  logic        usb_tvalid_i, usb_tlast_i, usb_tready_i, ctl_done_i;
  logic        ctl_tvalid_i, ctl_tlast_i;
  logic [7:0]  usb_tdata_i, ctl_tdata_i, usb_tdata_o, ctl_tdata_o;
  logic        hsk_send_o, trn_send_o, usb_tvalid_o, usb_tlast_o;
  logic        ep0_ce_o, ctl_start_o, ctl_tvalid_o, ctl_tlast_o, ctl_tready_o;
  logic [7:0]  ctl_rtype_o, ctl_rargs_o;
  logic [15:0] ctl_value_o, ctl_index_o, ctl_length_o;

  // Expected traffic, filled by the host models
  setup_t      setup_q[$];
  logic [8:0]  out_q[$];
  logic [7:0]  in_q[$];
  logic [2:0]  pkt_q[$];

  logic [31:0] rng;
  string       test_name;
  int          errors;
  int          starts;
  int          tests_run;
  int          cyc;
  int          rx_ref;
  logic        hsk_prev, trn_prev;

  usb_transaction #(.CTL_ENDP(CTL_ENDP)) i_dut (.*);

  initial begin : clock_gen
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [7:0] next_byte();
    rng = xorshift32(rng);
    return rng[7:0];
  endfunction

  function automatic logic [63:0] random_bytes();
    logic [63:0] raw;
    for (int i = 0; i < 8; i++) begin
      raw[8*i +: 8] = next_byte();
    end
    return raw;
  endfunction

  // Packet length of 1 to 8 bytes
  function automatic int rand_len();
    logic [7:0] b;
    b = next_byte();
    return 1 + int'(b[2:0]);
  endfunction

  // Setup bytes are little-endian with byte 0 in the low bits
  function automatic setup_t expect_setup(input logic [63:0] raw);
    setup_t s;
    s.rtype  = raw[7:0];
    s.rargs  = raw[15:8];
    s.value  = raw[31:16];
    s.index  = raw[47:32];
    s.length = raw[63:48];
    return s;
  endfunction

  // Data stage starts with DATA1 and toggles per acknowledged packet
  function automatic logic [1:0] expect_pid(input int k);
    return (k % 2 == 0) ? DATA1 : DATA0;
  endfunction

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("FAIL %s %s: expected %0h, actual %0h", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic note_error(input string msg);
    $display("ERROR %s: %s", test_name, msg);
    errors++;
  endtask

  // Compare process samples at the falling edge where all signals are settled
  always @(negedge clock) begin : compare
    setup_t     exp_s;
    logic [2:0] exp_p;
    if (!reset) begin
      cyc++;
      // Control source sees the encoder ready directly
      check_val("ctl_tready", 32'(usb_tready_i), 32'(ctl_tready_o));
      // Handshake timing counts from the last byte, or the DATA1 strobe if empty
      if (usb_recv_i || (usb_tvalid_i && usb_tlast_i)) rx_ref = cyc;
      if (ctl_start_o) begin
        starts++;
        assert (setup_q.size() > 0) else note_error("start strobe with no setup packet sent");
        if (setup_q.size() > 0) begin
          exp_s = setup_q.pop_front();
          check_val("rtype", 32'(exp_s.rtype), 32'(ctl_rtype_o));
          check_val("rargs", 32'(exp_s.rargs), 32'(ctl_rargs_o));
          check_val("value", 32'(exp_s.value), 32'(ctl_value_o));
          check_val("index", 32'(exp_s.index), 32'(ctl_index_o));
          check_val("length", 32'(exp_s.length), 32'(ctl_length_o));
        end
      end
      if (hsk_send_o && !hsk_prev) begin
        check_val("hsk type", 32'(HSK_ACK), 32'(hsk_type_o));
        check_val("ACK delay", 32'd2, 32'(cyc - rx_ref));
      end
      if (trn_send_o && !trn_prev) begin
        assert (pkt_q.size() > 0) else note_error("packet requested with no IN token");
        if (pkt_q.size() > 0) begin
          exp_p = pkt_q.pop_front();
          check_val("packet ID", 32'(exp_p[1:0]), 32'(trn_type_o));
          // Zero-length status shows no beats and an immediate last
          if (exp_p[2]) begin
            check_val("empty tvalid", 32'd0, 32'(usb_tvalid_o));
            check_val("empty tlast", 32'd1, 32'(usb_tlast_o));
          end
        end
      end
      if (usb_tvalid_o && usb_tready_i) begin
        assert (in_q.size() > 0) else note_error("unexpected beat on usb_tdata_o");
        if (in_q.size() > 0) check_val("IN byte", 32'(in_q.pop_front()), 32'(usb_tdata_o));
      end
      if (ctl_tvalid_o) begin
        assert (out_q.size() > 0) else note_error("unexpected beat on ctl_tdata_o");
        if (out_q.size() > 0) begin
          check_val("OUT byte", 32'(out_q.pop_front()), 32'({ctl_tlast_o, ctl_tdata_o}));
        end
      end
    end
    hsk_prev = hsk_send_o;
    trn_prev = trn_send_o;
  end

  task automatic send_token(input logic [1:0] kind, input logic [6:0] addr,
                            input logic [3:0] endp);
    @(posedge clock);
    #1;
    tok_recv_i = 1'b1;
    tok_type_i = kind;
    tok_addr_i = addr;
    tok_endp_i = endp;
    @(posedge clock);
    #1;
    tok_recv_i = 1'b0;
  endtask

  // Host data packet with the receive strobe first and then the bytes
  task automatic send_packet(input logic [1:0] pid, input int n, input logic [63:0] raw,
                             input logic to_ctl);
    usb_recv_i = 1'b1;
    usb_type_i = pid;
    @(posedge clock);
    #1;
    usb_recv_i = 1'b0;
    for (int i = 0; i < n; i++) begin
      usb_tvalid_i = 1'b1;
      usb_tdata_i  = raw[8*i +: 8];
      usb_tlast_i  = (i == n - 1);
      if (to_ctl) out_q.push_back({usb_tlast_i, usb_tdata_i});
      @(posedge clock);
      #1;
    end
    usb_tvalid_i = 1'b0;
    usb_tlast_i  = 1'b0;
  endtask

  // Encoder sends the device ACK a little later
  task automatic take_dev_ack();
    wait (hsk_send_o);
    repeat (2) @(posedge clock);
    #1;
    hsk_sent_i = 1'b1;
    @(posedge clock);
    #1;
    hsk_sent_i = 1'b0;
  endtask

  task automatic host_ack();
    @(posedge clock);
    #1;
    hsk_recv_i = 1'b1;
    hsk_type_i = HSK_ACK;
    @(posedge clock);
    #1;
    hsk_recv_i = 1'b0;
  endtask

  task automatic encoder_take();
    wait (trn_send_o);
    @(posedge clock);
    #1;
    trn_busy_i = 1'b1;
    @(posedge clock);
    #1;
    trn_busy_i = 1'b0;
  endtask

  task automatic setup_stage(input logic [63:0] raw);
    int s0;
    setup_q.push_back(expect_setup(raw));
    s0 = starts;
    send_token(TOK_SETUP, DEV_ADDR, CTL_EP);
    check_val("ep0_ce after SETUP", 32'd1, 32'(ep0_ce_o));
    send_packet(DATA0, 8, raw, 1'b0);
    take_dev_ack();
    check_val("start pulses", 32'd1, 32'(starts - s0));
  endtask

  // IN packet from the control source, with random encoder back-pressure
  task automatic in_packet(input int k, input int n, input logic last);
    logic [7:0] b;
    int         i;
    pkt_q.push_back({1'b0, expect_pid(k)});
    send_token(TOK_IN, DEV_ADDR, CTL_EP);
    encoder_take();
    i = 0;
    b = next_byte();
    while (i < n) begin
      ctl_tvalid_i = 1'b1;
      ctl_tdata_i  = b;
      ctl_tlast_i  = (i == n - 1);
      usb_tready_i = next_byte() > 8'd80;
      if (usb_tready_i) begin
        in_q.push_back(b);
        i++;
        b = next_byte();
      end
      @(posedge clock);
      #1;
    end
    ctl_tvalid_i = 1'b0;
    ctl_tlast_i  = 1'b0;
    usb_tready_i = 1'b1;
    ctl_done_i   = last;
    host_ack();
  endtask

  task automatic out_packet(input int k, input int n, input logic last);
    send_token(TOK_OUT, DEV_ADDR, CTL_EP);
    send_packet(expect_pid(k), n, random_bytes(), 1'b1);
    ctl_done_i = last;
    take_dev_ack();
  endtask

  task automatic status_in();
    pkt_q.push_back({1'b1, DATA1});
    send_token(TOK_IN, DEV_ADDR, CTL_EP);
    encoder_take();
    host_ack();
  endtask

  task automatic status_out();
    send_token(TOK_OUT, DEV_ADDR, CTL_EP);
    send_packet(DATA1, 0, '0, 1'b0);
    take_dev_ack();
  endtask

  // Kind 0 ignored tokens, 1 IN data, 2 OUT data, 3 no data stage
  task automatic run_test(input string name, input int kind);
    logic [63:0] raw;
    int          e0;
    test_name  = name;
    e0         = errors;
    ctl_done_i = 1'b0;
    raw        = random_bytes();
    case (kind)
      0: begin
        send_token(TOK_SETUP, DEV_ADDR ^ 7'h01, CTL_EP);
        check_val("ep0_ce wrong addr", 32'd0, 32'(ep0_ce_o));
        send_token(TOK_SETUP, DEV_ADDR, CTL_EP + 4'd1);
        check_val("ep0_ce wrong endp", 32'd0, 32'(ep0_ce_o));
        send_token(TOK_IN, DEV_ADDR, CTL_EP);
        check_val("ep0_ce idle IN", 32'd0, 32'(ep0_ce_o));
      end
      1: begin
        raw[63:48] = 16'h0040;
        setup_stage(raw);
        for (int k = 0; k < 3; k++) in_packet(k, rand_len(), k == 2);
        status_out();
      end
      2: begin
        raw[63:48] = 16'h0010;
        setup_stage(raw);
        for (int k = 0; k < 2; k++) out_packet(k, rand_len(), k == 1);
        status_in();
      end
      default: begin
        raw[63:48] = 16'h0000;
        setup_stage(raw);
        status_in();
      end
    endcase
    wait (!ep0_ce_o);
    repeat (3) @(posedge clock);
    #1;
    assert (setup_q.size() == 0 && pkt_q.size() == 0)
      else note_error("setup fields or packet request never seen");
    assert (in_q.size() == 0 && out_q.size() == 0)
      else note_error("stream bytes never seen at the far side");
    tests_run++;
    if (errors == e0) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, errors - e0);
  endtask

  initial begin : stimulus
    rng          = SEED;
    errors       = 0;
    starts       = 0;
    tests_run    = 0;
    cyc          = 0;
    rx_ref       = 0;
    reset        = 1'b1;
    usb_addr_i   = DEV_ADDR;
    tok_recv_i   = 1'b0;
    tok_type_i   = TOK_OUT;
    tok_addr_i   = '0;
    tok_endp_i   = '0;
    hsk_recv_i   = 1'b0;
    hsk_type_i   = HSK_ACK;
    hsk_sent_i   = 1'b0;
    usb_recv_i   = 1'b0;
    usb_type_i   = DATA0;
    usb_tvalid_i = 1'b0;
    usb_tlast_i  = 1'b0;
    usb_tdata_i  = '0;
    trn_busy_i   = 1'b0;
    usb_tready_i = 1'b1;
    ctl_done_i   = 1'b0;
    ctl_tvalid_i = 1'b0;
    ctl_tlast_i  = 1'b0;
    ctl_tdata_i  = '0;
    repeat (10) @(posedge clock);
    #1;
    reset = 1'b0;
    // Outputs must come out of reset idle
    check_val("ep0_ce after reset", 32'd0, 32'({ep0_ce_o, ctl_start_o, hsk_send_o}));
    check_val("encoder after reset", 32'd0, 32'({trn_send_o, usb_tvalid_o}));
    run_test("ignore_tokens", 0);
    run_test("in_data_stage", 1);
    run_test("out_data_stage", 2);
    run_test("no_data_stage", 3);
    $display("%0d tests run, %0d errors", tests_run, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    #(CLK_PERIOD * (10 + NUM_TESTS * XFER_CYCLES));
    $display("watchdog expired, the DUT stopped answering during %s", test_name);
    $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== dv/usb_transaction_sva.sv ====
module usb_transaction_sva (
  input logic                     clock,
  input logic                     reset,
  input logic                     ctl_start_o,
  input logic                     hsk_send_o,
  input logic                     hsk_sent_i,
  input logic                     trn_send_o,
  input logic                     trn_busy_i,
  input ctl_xfer_pkg::ctl_state_e fsm_state
);
  timeunit 1ns;
  timeprecision 1ps;

  // Start strobe is a single-cycle pulse
  start_one_cycle: assert property (@(posedge clock) disable iff (reset)
    ctl_start_o |=> !ctl_start_o)
    else $error("ctl_start_o lasted more than one cycle");

  // Handshake request held until the encoder reports it sent
  hsk_held: assert property (@(posedge clock) disable iff (reset)
    hsk_send_o && !hsk_sent_i |=> hsk_send_o)
    else $error("hsk_send_o dropped before hsk_sent_i");

  // Packet request held until the encoder goes busy
  trn_held: assert property (@(posedge clock) disable iff (reset)
    trn_send_o && !trn_busy_i |=> trn_send_o)
    else $error("trn_send_o dropped before trn_busy_i");

  // ACK only goes out from one of the handshake stages
  hsk_stage: assert property (@(posedge clock) disable iff (reset)
    $rose(hsk_send_o) |-> fsm_state inside {ctl_xfer_pkg::SETUP_ACK,
      ctl_xfer_pkg::DATO_ACK, ctl_xfer_pkg::STATUS_ACK})
    else $error("hsk_send_o rose outside a handshake stage");

endmodule

bind usb_transaction usb_transaction_sva i_sva (
  .clock       (clock),
  .reset       (reset),
  .ctl_start_o (ctl_start_o),
  .hsk_send_o  (hsk_send_o),
  .hsk_sent_i  (hsk_sent_i),
  .trn_send_o  (trn_send_o),
  .trn_busy_i  (trn_busy_i),
  .fsm_state   (u_control_fsm.state)
);

// ==== hdl/usb_transaction.sv ====
module usb_transaction #(
  parameter int unsigned CTL_ENDP = 0
) (
  input  logic                            clock,
  input  logic                            reset,
  input  logic [usb_pid_pkg::ADDR_W-1:0]  usb_addr_i,
  // Decoded tokens from the host
  input  logic                            tok_recv_i,
  input  logic [1:0]                      tok_type_i,
  input  logic [usb_pid_pkg::ADDR_W-1:0]  tok_addr_i,
  input  logic [usb_pid_pkg::ENDP_W-1:0]  tok_endp_i,
  // Handshakes in both directions
  input  logic                            hsk_recv_i,
  input  logic [1:0]                      hsk_type_i,
  output logic                            hsk_send_o,
  input  logic                            hsk_sent_i,
  output logic [1:0]                      hsk_type_o,
  // Data packets from the decoder
  input  logic                            usb_recv_i,
  input  logic [1:0]                      usb_type_i,
  input  logic                            usb_tvalid_i,
  input  logic                            usb_tlast_i,
  input  logic [ctl_xfer_pkg::BYTE_W-1:0] usb_tdata_i,
  // Packet requests and IN stream to the encoder
  output logic                            trn_send_o,
  output logic [1:0]                      trn_type_o,
  input  logic                            trn_busy_i,
  output logic                            usb_tvalid_o,
  input  logic                            usb_tready_i,
  output logic                            usb_tlast_o,
  output logic [ctl_xfer_pkg::BYTE_W-1:0] usb_tdata_o,
  // Control endpoint
  output logic                            ep0_ce_o,
  output logic                            ctl_start_o,
  input  logic                            ctl_done_i,
  output logic [ctl_xfer_pkg::BYTE_W-1:0] ctl_rtype_o,
  output logic [ctl_xfer_pkg::BYTE_W-1:0] ctl_rargs_o,
  output logic [ctl_xfer_pkg::WORD_W-1:0] ctl_value_o,
  output logic [ctl_xfer_pkg::WORD_W-1:0] ctl_index_o,
  output logic [ctl_xfer_pkg::WORD_W-1:0] ctl_length_o,
  output logic                            ctl_tvalid_o,
  output logic                            ctl_tlast_o,
  output logic [ctl_xfer_pkg::BYTE_W-1:0] ctl_tdata_o,
  input  logic                            ctl_tvalid_i,
  output logic                            ctl_tready_o,
  input  logic                            ctl_tlast_i,
  input  logic [ctl_xfer_pkg::BYTE_W-1:0] ctl_tdata_i
);

  logic                   ctl_active;
  logic                   xfer_done;
  logic                   send_zero;
  logic                   send_data;
  usb_pid_pkg::data_pid_e data_pid;

  setup_req_if req ();

  token_router #(
    .CTL_ENDP (CTL_ENDP)
  ) u_token_router (
    .clock        (clock),
    .reset        (reset),
    .usb_addr_i   (usb_addr_i),
    .tok_recv_i   (tok_recv_i),
    .tok_type_i   (tok_type_i),
    .tok_addr_i   (tok_addr_i),
    .tok_endp_i   (tok_endp_i),
    .xfer_done_i  (xfer_done),
    .ctl_active_o (ctl_active),
    .ep0_ce_o     (ep0_ce_o)
  );

  setup_parser u_setup_parser (
    .clock        (clock),
    .reset        (reset),
    .ctl_active_i (ctl_active),
    .usb_tvalid_i (usb_tvalid_i),
    .usb_tdata_i  (usb_tdata_i),
    .req          (req.parser)
  );

  control_fsm u_control_fsm (
    .clock        (clock),
    .reset        (reset),
    .ctl_active_i (ctl_active),
    .tok_recv_i   (tok_recv_i),
    .tok_type_i   (tok_type_i),
    .hsk_recv_i   (hsk_recv_i),
    .hsk_type_i   (hsk_type_i),
    .hsk_sent_i   (hsk_sent_i),
    .usb_recv_i   (usb_recv_i),
    .usb_type_i   (usb_type_i),
    .usb_tvalid_i (usb_tvalid_i),
    .usb_tlast_i  (usb_tlast_i),
    .usb_tdata_i  (usb_tdata_i),
    .ctl_done_i   (ctl_done_i),
    .ctl_tvalid_i (ctl_tvalid_i),
    .ctl_tlast_i  (ctl_tlast_i),
    .usb_tready_i (usb_tready_i),
    .req          (req.fsm),
    .hsk_send_o   (hsk_send_o),
    .hsk_type_o   (hsk_type_o),
    .send_zero_o  (send_zero),
    .send_data_o  (send_data),
    .data_pid_o   (data_pid),
    .xfer_done_o  (xfer_done),
    .ctl_tvalid_o (ctl_tvalid_o),
    .ctl_tlast_o  (ctl_tlast_o),
    .ctl_tdata_o  (ctl_tdata_o)
  );

  in_packet_tx u_in_packet_tx (
    .clock        (clock),
    .reset        (reset),
    .send_zero_i  (send_zero),
    .send_data_i  (send_data),
    .data_pid_i   (data_pid),
    .trn_busy_i   (trn_busy_i),
    .ctl_tvalid_i (ctl_tvalid_i),
    .ctl_tlast_i  (ctl_tlast_i),
    .ctl_tdata_i  (ctl_tdata_i),
    .trn_send_o   (trn_send_o),
    .trn_type_o   (trn_type_o),
    .usb_tvalid_o (usb_tvalid_o),
    .usb_tlast_o  (usb_tlast_o),
    .usb_tdata_o  (usb_tdata_o)
  );

  // Request fields straight out to the control endpoint
  assign ctl_start_o  = req.start;
  assign ctl_rtype_o  = req.rtype;
  assign ctl_rargs_o  = req.rargs;
  assign ctl_value_o  = req.value;
  assign ctl_index_o  = req.index;
  assign ctl_length_o = req.length;

  // Encoder back-pressure stalls the control source directly
  assign ctl_tready_o = usb_tready_i;

endmodule

// ==== hdl/in_packet_tx.sv ====
module in_packet_tx (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            send_zero_i,
  input  logic                            send_data_i,
  input  usb_pid_pkg::data_pid_e          data_pid_i,
  input  logic                            trn_busy_i,
  input  logic                            ctl_tvalid_i,
  input  logic                            ctl_tlast_i,
  input  logic [ctl_xfer_pkg::BYTE_W-1:0] ctl_tdata_i,
  output logic                            trn_send_o,
  output usb_pid_pkg::data_pid_e          trn_type_o,
  output logic                            usb_tvalid_o,
  output logic                            usb_tlast_o,
  output logic [ctl_xfer_pkg::BYTE_W-1:0] usb_tdata_o
);

  logic                   send_q;
  logic                   zero_q;
  usb_pid_pkg::data_pid_e type_q;

  // Send request, held until the encoder reports busy
  always_ff @(posedge clock) begin
    if (reset) begin
      send_q <= 1'b0;
    end else if (send_zero_i || send_data_i) begin
      send_q <= 1'b1;
    end else if (trn_busy_i) begin
      send_q <= 1'b0;
    end
  end

  // Zero-length flag lasts until the next data packet is requested
  always_ff @(posedge clock) begin
    if (reset) begin
      zero_q <= 1'b0;
    end else if (send_zero_i) begin
      zero_q <= 1'b1;
    end else if (send_data_i) begin
      zero_q <= 1'b0;
    end
  end

  // Status packet is always DATA1
  always_ff @(posedge clock) begin
    if (send_zero_i) begin
      type_q <= usb_pid_pkg::DATA1;
    end else if (send_data_i) begin
      type_q <= data_pid_i;
    end
  end

  assign trn_send_o = send_q;
  assign trn_type_o = type_q;

  // Stream mux, an empty packet shows no beats but an immediate last
  assign usb_tvalid_o = zero_q ? 1'b0 : ctl_tvalid_i;
  assign usb_tlast_o  = zero_q ? 1'b1 : ctl_tlast_i;
  assign usb_tdata_o  = ctl_tdata_i;

endmodule

// ==== hdl/control_fsm.sv ====
module control_fsm (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            ctl_active_i,
  input  logic                            tok_recv_i,
  input  logic [1:0]                      tok_type_i,
  input  logic                            hsk_recv_i,
  input  logic [1:0]                      hsk_type_i,
  input  logic                            hsk_sent_i,
  input  logic                            usb_recv_i,
  input  logic [1:0]                      usb_type_i,
  input  logic                            usb_tvalid_i,
  input  logic                            usb_tlast_i,
  input  logic [ctl_xfer_pkg::BYTE_W-1:0] usb_tdata_i,
  input  logic                            ctl_done_i,
  input  logic                            ctl_tvalid_i,
  input  logic                            ctl_tlast_i,
  input  logic                            usb_tready_i,
  setup_req_if.fsm                        req,
  output logic                            hsk_send_o,
  output usb_pid_pkg::hsk_type_e          hsk_type_o,
  output logic                            send_zero_o,
  output logic                            send_data_o,
  output usb_pid_pkg::data_pid_e          data_pid_o,
  output logic                            xfer_done_o,
  output logic                            ctl_tvalid_o,
  output logic                            ctl_tlast_o,
  output logic [ctl_xfer_pkg::BYTE_W-1:0] ctl_tdata_o
);

  ctl_xfer_pkg::ctl_state_e state;
  usb_pid_pkg::data_pid_e   pid_q;

  logic rx_last, rx_empty, tx_last;
  logic tok_in, tok_out, host_ack;
  logic recv_q, ack_req, ack_empty, hsk_send_q;
  logic send_zero_q, send_data_q, xfer_done_q;

  // Last byte of a packet from the host
  assign rx_last  = usb_tvalid_i && usb_tlast_i;
  // DATA1 seen a cycle ago and still no byte, so the packet is empty
  assign rx_empty = recv_q && !usb_tvalid_i;
  // Last byte of an IN packet taken by the encoder
  assign tx_last  = ctl_tvalid_i && usb_tready_i && ctl_tlast_i;

  // Empty status packet is acknowledged straight from the delayed strobe
  assign ack_empty = state == ctl_xfer_pkg::STATUS_RX && rx_empty;

  assign tok_in   = tok_recv_i && tok_type_i == usb_pid_pkg::TOK_IN;
  assign tok_out  = tok_recv_i && tok_type_i == usb_pid_pkg::TOK_OUT;
  assign host_ack = hsk_recv_i && hsk_type_i == usb_pid_pkg::HSK_ACK;

  // Stage sequencing restarts whenever the router drops the transfer
  always_ff @(posedge clock) begin
    if (reset || !ctl_active_i) begin
      state       <= ctl_xfer_pkg::SETUP_RX;
      pid_q       <= usb_pid_pkg::DATA1;
      send_zero_q <= 1'b0;
      send_data_q <= 1'b0;
      xfer_done_q <= 1'b0;
    end else begin
      send_zero_q <= 1'b0;
      send_data_q <= 1'b0;
      xfer_done_q <= 1'b0;
      case (state)
        ctl_xfer_pkg::SETUP_RX: if (rx_last) state <= ctl_xfer_pkg::SETUP_ACK;
        ctl_xfer_pkg::SETUP_ACK: begin
          // First data packet is always DATA1
          if (hsk_sent_i) begin
            pid_q <= usb_pid_pkg::DATA1;
            state <= req.length == '0 ? ctl_xfer_pkg::STATUS_TOK : ctl_xfer_pkg::DATA_TOK;
          end
        end
        ctl_xfer_pkg::DATA_TOK: begin
          if (tok_in) begin
            send_data_q <= 1'b1;
            state       <= ctl_xfer_pkg::DATI_TX;
          end else if (tok_out) begin
            state <= ctl_xfer_pkg::DATO_RX;
          end
        end
        ctl_xfer_pkg::DATO_RX: if (rx_last) state <= ctl_xfer_pkg::DATO_ACK;
        ctl_xfer_pkg::DATO_ACK: begin
          if (hsk_sent_i) begin
            pid_q <= pid_q == usb_pid_pkg::DATA1 ? usb_pid_pkg::DATA0 : usb_pid_pkg::DATA1;
            state <= ctl_done_i ? ctl_xfer_pkg::STATUS_TOK : ctl_xfer_pkg::DATA_TOK;
          end
        end
        ctl_xfer_pkg::DATI_TX: if (tx_last) state <= ctl_xfer_pkg::DATI_ACK;
        ctl_xfer_pkg::DATI_ACK: begin
          // Host ACK moves the toggle on, a NAK resends the same packet
          if (host_ack) begin
            pid_q <= pid_q == usb_pid_pkg::DATA1 ? usb_pid_pkg::DATA0 : usb_pid_pkg::DATA1;
            state <= ctl_done_i ? ctl_xfer_pkg::STATUS_TOK : ctl_xfer_pkg::DATA_TOK;
          end else if (hsk_recv_i) begin
            state <= ctl_xfer_pkg::DATA_TOK;
          end
        end
        ctl_xfer_pkg::STATUS_TOK: begin
          // Zero-length status IN, or expect one from the host on OUT
          if (tok_in) begin
            send_zero_q <= 1'b1;
            state       <= ctl_xfer_pkg::STATUS_TX;
          end else if (tok_out) begin
            state <= ctl_xfer_pkg::STATUS_RX;
          end
        end
        ctl_xfer_pkg::STATUS_RX: begin
          if (rx_last || rx_empty) state <= ctl_xfer_pkg::STATUS_ACK;
        end
        ctl_xfer_pkg::STATUS_TX: state <= ctl_xfer_pkg::STATUS_ACK;
        ctl_xfer_pkg::STATUS_ACK: begin
          if (hsk_sent_i || host_ack) begin
            xfer_done_q <= 1'b1;
            state       <= ctl_xfer_pkg::DONE;
          end
        end
        // Wait here for the router to drop the chip-enable
        default: state <= ctl_xfer_pkg::DONE;
      endcase
    end
  end

  // Receive strobe alignment and ACK request
  always_ff @(posedge clock) begin
    if (reset || !ctl_active_i) begin
      recv_q  <= 1'b0;
      ack_req <= 1'b0;
    end else begin
      recv_q <= usb_recv_i && usb_type_i == usb_pid_pkg::DATA1;
      case (state)
        ctl_xfer_pkg::SETUP_RX,
        ctl_xfer_pkg::DATO_RX,
        ctl_xfer_pkg::STATUS_RX: ack_req <= rx_last;
        default:                 ack_req <= 1'b0;
      endcase
    end
  end

  // Handshake request held as a level until the encoder has sent it
  always_ff @(posedge clock) begin
    if (reset) begin
      hsk_send_q <= 1'b0;
    end else if (ack_req || ack_empty) begin
      hsk_send_q <= 1'b1;
    end else if (hsk_sent_i) begin
      hsk_send_q <= 1'b0;
    end
  end

  assign hsk_send_o  = hsk_send_q;
  // Device only ever ACKs on the control pipe
  assign hsk_type_o  = usb_pid_pkg::HSK_ACK;
  assign send_zero_o = send_zero_q;
  assign send_data_o = send_data_q;
  assign data_pid_o  = pid_q;
  assign xfer_done_o = xfer_done_q;

  // OUT data goes to the control endpoint only during the data stage
  assign ctl_tvalid_o = state == ctl_xfer_pkg::DATO_RX && usb_tvalid_i;
  assign ctl_tlast_o  = state == ctl_xfer_pkg::DATO_RX && usb_tlast_i;
  assign ctl_tdata_o  = usb_tdata_i;

endmodule

// ==== hdl/setup_parser.sv ====
module setup_parser (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            ctl_active_i,
  input  logic                            usb_tvalid_i,
  input  logic [ctl_xfer_pkg::BYTE_W-1:0] usb_tdata_i,
  setup_req_if.parser                     req
);

  localparam int CNT_W = ctl_xfer_pkg::SETUP_CNT_W;

  logic [CNT_W-1:0] count;
  logic             full;
  logic             take;

  // Only the first eight bytes of the transfer belong to the setup packet
  assign take = ctl_active_i && usb_tvalid_i && !full;

  // Byte counter and start strobe
  always_ff @(posedge clock) begin
    if (reset || !ctl_active_i) begin
      count     <= '0;
      full      <= 1'b0;
      req.start <= 1'b0;
    end else begin
      req.start <= 1'b0;
      if (take) begin
        count <= count + 1'b1;
        if (count == CNT_W'(ctl_xfer_pkg::SETUP_BYTES - 1)) begin
          full      <= 1'b1;
          req.start <= 1'b1;
        end
      end
    end
  end

  // Little-endian fields, held until the next transfer overwrites them
  always_ff @(posedge clock) begin
    if (take) begin
      case (count)
        3'd0: req.rtype <= usb_tdata_i;
        3'd1: req.rargs <= usb_tdata_i;
        3'd2: req.value[7:0] <= usb_tdata_i;
        3'd3: req.value[15:8] <= usb_tdata_i;
        3'd4: req.index[7:0] <= usb_tdata_i;
        3'd5: req.index[15:8] <= usb_tdata_i;
        3'd6: req.length[7:0] <= usb_tdata_i;
        3'd7: req.length[15:8] <= usb_tdata_i;
      endcase
    end
  end

endmodule

// ==== hdl/token_router.sv ====
module token_router #(
  parameter int unsigned CTL_ENDP = 0
) (
  input  logic                           clock,
  input  logic                           reset,
  input  logic [usb_pid_pkg::ADDR_W-1:0] usb_addr_i,
  input  logic                           tok_recv_i,
  input  logic [1:0]                     tok_type_i,
  input  logic [usb_pid_pkg::ADDR_W-1:0] tok_addr_i,
  input  logic [usb_pid_pkg::ENDP_W-1:0] tok_endp_i,
  input  logic                           xfer_done_i,
  output logic                           ctl_active_o,
  output logic                           ep0_ce_o
);

  // Endpoint number trimmed to the token field width
  localparam logic [usb_pid_pkg::ENDP_W-1:0] CTL_EP = CTL_ENDP[usb_pid_pkg::ENDP_W-1:0];

  typedef enum logic {
    TRN_IDLE,
    TRN_CTRL
  } trn_state_e;

  trn_state_e state;
  logic       setup_hit;

  // SETUP token for our address on the control endpoint
  assign setup_hit = tok_recv_i && tok_addr_i == usb_addr_i &&
                     tok_endp_i == CTL_EP && tok_type_i == usb_pid_pkg::TOK_SETUP;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= TRN_IDLE;
    end else begin
      case (state)
        // Anything other than a matching SETUP is ignored here
        TRN_IDLE: if (setup_hit) state <= TRN_CTRL;
        // Held until the control FSM reports the status stage done
        TRN_CTRL: if (xfer_done_i) state <= TRN_IDLE;
      endcase
    end
  end

  // Chip-enable and the internal active flag are the same level
  assign ep0_ce_o     = state == TRN_CTRL;
  assign ctl_active_o = state == TRN_CTRL;

endmodule

// ==== hdl/setup_req_if.sv ====
interface setup_req_if;

  // Parsed setup request fields
  logic [ctl_xfer_pkg::BYTE_W-1:0] rtype;
  logic [ctl_xfer_pkg::BYTE_W-1:0] rargs;
  logic [ctl_xfer_pkg::WORD_W-1:0] value;
  logic [ctl_xfer_pkg::WORD_W-1:0] index;
  logic [ctl_xfer_pkg::WORD_W-1:0] length;
  // One-cycle strobe once all eight bytes are in
  logic start;

  modport parser (output rtype, rargs, value, index, length, start);

  // FSM only needs to know if a data stage follows
  modport fsm (input length);

  // Top level view, fields go out to the control endpoint
  modport mon (input rtype, rargs, value, index, length, start);

endinterface

// ==== hdl/ctl_xfer_pkg.sv ====
package ctl_xfer_pkg;

  // Setup packet is always eight bytes
  localparam int SETUP_BYTES = 8;
  localparam int SETUP_CNT_W = $clog2(SETUP_BYTES);

  // Field widths of the setup request
  localparam int BYTE_W = 8;
  localparam int WORD_W = 16;

  // Control transfer stages
  typedef enum logic [3:0] {
    SETUP_RX,
    SETUP_ACK,
    // Data stage, OUT and IN directions
    DATA_TOK,
    DATO_RX,
    DATO_ACK,
    DATI_TX,
    DATI_ACK,
    // Status stage, opposite direction to data
    STATUS_TOK,
    STATUS_RX,
    STATUS_TX,
    STATUS_ACK,
    DONE
  } ctl_state_e;

endpackage

// ==== hdl/usb_pid_pkg.sv ====
package usb_pid_pkg;

  // Device address and endpoint number widths
  localparam int ADDR_W = 7;
  localparam int ENDP_W = 4;

  // Token packet types, as decoded from the PID
  typedef enum logic [1:0] {
    TOK_OUT   = 2'b00,
    TOK_IN    = 2'b10,
    TOK_SETUP = 2'b11
  } tok_type_e;

  // Handshake packet types
  typedef enum logic [1:0] {
    HSK_ACK = 2'b00,
    HSK_NAK = 2'b10
  } hsk_type_e;

  // Data packet IDs, toggled across a data stage
  typedef enum logic [1:0] {
    DATA0 = 2'b00,
    DATA1 = 2'b10
  } data_pid_e;

endpackage
